// File: dcache_top.f
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_init_sweep.sv
rtl/dcache_meta.sv
rtl/dcache_data_ram.sv
rtl/dcache_datapath.sv
rtl/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// File: verification/dcache_cases.txt
// op (0 load, 1 store) then word address, write data and byte mask in hex
// Low four address bits select the line and the rest is the tag
0 00005 00000000 0
0 00005 00000000 0
1 00012 deadbeef f
0 00012 00000000 0
1 00005 000000ab 1
0 00005 00000000 0
1 00037 12345600 6
0 00037 00000000 0
0 10005 00000000 0
0 00005 00000000 0
1 04012 cafef00d f
0 00012 00000000 0
1 00037 00000077 1
1 00047 aa000000 8
0 00037 00000000 0

// File: verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam int          INDEX_W   = 4;
    localparam int          TAG_W     = 13;
    localparam int          sweep_len = 2 ** INDEX_W;
    localparam int          max_cases = 32;
    localparam int          max_wb    = 64;
    localparam logic [31:0] fill_xor  = 32'h5a3c_96e1;

    logic                          clk_i = 1'b0;
    logic                          rst_i;
    dcache_pkg::cpu_req_t          cpu_req;
    logic                          stall;
    logic [dcache_pkg::data_w-1:0] rdata;
    dcache_pkg::mem_req_t          mem_req;
    dcache_pkg::mem_rsp_t          mem_rsp;

    logic [31:0]                   cases [max_cases*4];
    logic [dcache_pkg::data_w-1:0] golden [2 ** dcache_pkg::addr_w];
    logic [TAG_W-1:0]              line_tag [sweep_len];
    logic                          line_valid [sweep_len];
    logic                          line_dirty [sweep_len];
    logic [dcache_pkg::addr_w-1:0] wb_addr [max_wb];
    logic [dcache_pkg::data_w-1:0] wb_data [max_wb];
    int                            wb_seen      = 0;
    int                            num_cases    = 0;
    logic                          cases_ready  = 1'b0;
    int                            check_errors = 0;
    int                            bus_errors   = 0;
    int                            since_reset  = 0;
    logic                          hold_q       = 1'b0;
    dcache_pkg::mem_req_t          prev_req;

    always #2 clk_i = ~clk_i;

    dcache_top #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) DUT (
        .clk_i(clk_i), .rst_i(rst_i), .cpu_req_i(cpu_req), .stall_o(stall),
        .rdata_o(rdata), .mem_req_o(mem_req), .mem_rsp_i(mem_rsp)
    );

    dcache_mem_model #(.FILL_XOR(fill_xor), .SEED(8'd81)) u_mem (
        .clk_i(clk_i), .rst_i(rst_i), .mem_req_i(mem_req), .mem_rsp_o(mem_rsp)
    );

    function automatic logic [31:0] pattern_word(input logic [16:0] addr);
        return {15'd0, addr} ^ fill_xor;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  mask);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Memory bus monitor sampled mid-cycle
    always @(negedge clk_i) begin
        if (rst_i || since_reset < sweep_len) begin
            assert (mem_req.valid === 1'b0) else begin
                $display("ERROR t=%0t mem_req_o.valid: expected 0, got %b", $time, mem_req.valid);
                bus_errors++;
            end
            // Request held during the sweep must stall
            if (!rst_i && cpu_req.sel) begin
                assert (stall === 1'b1) else begin
                    $display("ERROR t=%0t stall_o: expected 1, got %b", $time, stall);
                    bus_errors++;
                end
            end
        end
        if (hold_q) begin
            assert (mem_req === prev_req) else begin
                $display("ERROR t=%0t mem_req_o: expected %h, got %h", $time, prev_req, mem_req);
                bus_errors++;
            end
        end
        if (mem_req.valid && mem_rsp.ready && mem_req.wstrb != '0) begin
            if (wb_seen < max_wb) begin
                wb_addr[wb_seen] = mem_req.addr;
                wb_data[wb_seen] = mem_req.wdata;
            end
            wb_seen++;
        end
        hold_q      = mem_req.valid && !mem_rsp.ready;
        prev_req    = mem_req;
        since_reset = rst_i ? 0 : since_reset + 1;
    end

    initial begin
        int                            wb_checked;
        logic [31:0]                   op;
        logic [dcache_pkg::addr_w-1:0] addr;
        logic [dcache_pkg::addr_w-1:0] victim_addr;
        logic [dcache_pkg::data_w-1:0] victim_data;
        logic [dcache_pkg::data_w-1:0] wdata;
        logic [dcache_pkg::strb_w-1:0] mask;
        logic [INDEX_W-1:0]            idx;
        logic [TAG_W-1:0]              tag;
        logic                          hit;
        logic                          exp_wb;

        rst_i      = 1'b1;
        cpu_req    = '0;
        wb_checked = 0;
        for (int a = 0; a < 2 ** dcache_pkg::addr_w; a++) begin
            golden[a] = pattern_word(a);
        end
        for (int i = 0; i < sweep_len; i++) begin
            line_tag[i]   = '0;
            line_valid[i] = 1'b0;
            line_dirty[i] = 1'b0;
        end
        for (int i = 0; i < max_cases * 4; i++) begin
            cases[i] = '1;
        end
        $readmemh("verification/dcache_cases.txt", cases);
        while (num_cases < max_cases && cases[4*num_cases] !== 32'hffff_ffff) begin
            num_cases++;
        end
        cases_ready = 1'b1;
        if (num_cases == 0) begin
            $display("No cases were read from the case file");
            check_errors++;
        end

        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // First request goes out right away and waits through the sweep
        for (int c = 0; c < num_cases; c++) begin
            op    = cases[4*c];
            addr  = cases[4*c+1][dcache_pkg::addr_w-1:0];
            wdata = cases[4*c+2];
            mask  = (op == 1) ? cases[4*c+3][dcache_pkg::strb_w-1:0] : '0;
            if (op > 1) begin
                $display("Case %0d has unknown operation %h and was skipped", c, op);
                check_errors++;
                continue;
            end

            idx         = addr[INDEX_W-1:0];
            tag         = addr[INDEX_W +: TAG_W];
            hit         = line_valid[idx] && line_tag[idx] == tag;
            exp_wb      = line_valid[idx] && line_dirty[idx] && !hit;
            victim_addr = {line_tag[idx], idx};
            victim_data = golden[victim_addr];
            if (!hit) begin
                line_tag[idx]   = tag;
                line_valid[idx] = 1'b1;
                line_dirty[idx] = 1'b0;
            end
            if (mask != '0) begin
                line_dirty[idx] = 1'b1;
                golden[addr]    = merge_bytes(golden[addr], wdata, mask);
            end

            cpu_req.sel   = 1'b1;
            cpu_req.addr  = addr;
            cpu_req.wdata = wdata;
            cpu_req.wmask = mask;
            @(negedge clk_i);
            while (stall) begin
                @(negedge clk_i);
            end

            if (mask == '0) begin
                assert (rdata === golden[addr]) else begin
                    $display("ERROR t=%0t rdata_o: expected %h, got %h at address %h",
                             $time, golden[addr], rdata, addr);
                    check_errors++;
                end
            end
            if (exp_wb) begin
                assert (wb_seen == wb_checked + 1) else begin
                    $display("Case %0d expected one write-back of the victim but saw %0d",
                             c, wb_seen - wb_checked);
                    check_errors++;
                end
                if (wb_seen > wb_checked && wb_checked < max_wb) begin
                    assert (wb_addr[wb_checked] === victim_addr) else begin
                        $display("ERROR t=%0t mem_req_o.addr: expected %h, got %h",
                                 $time, victim_addr, wb_addr[wb_checked]);
                        check_errors++;
                    end
                    assert (wb_data[wb_checked] === victim_data) else begin
                        $display("ERROR t=%0t mem_req_o.wdata: expected %h, got %h",
                                 $time, victim_data, wb_data[wb_checked]);
                        check_errors++;
                    end
                end
            end else begin
                assert (wb_seen == wb_checked) else begin
                    $display("Case %0d wrote to memory although no dirty line was evicted", c);
                    check_errors++;
                end
            end
            wb_checked = wb_seen;

            // Leave done, next request goes out in idle
            @(posedge clk_i);
            #1;
        end

        cpu_req = '0;
        repeat (4) @(posedge clk_i);
        $display("Errors: %0d check, %0d bus, %0d total",
                 check_errors, bus_errors, check_errors + bus_errors);
        if (check_errors + bus_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Forty cycles per case covers a dirty miss with the longest memory waits
    initial begin
        wait (cases_ready);
        repeat (8 + sweep_len + num_cases * 40 + 10) @(posedge clk_i);
        $display("Watchdog expired before all cases completed");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: verification/dcache_mem_model.sv
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter logic [31:0] FILL_XOR = 32'h5a3c_96e1,
    parameter logic [7:0]  SEED     = 8'd81
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  dcache_pkg::mem_req_t mem_req_i,
    output dcache_pkg::mem_rsp_t mem_rsp_o
);

    logic [dcache_pkg::data_w-1:0] mem [2 ** dcache_pkg::addr_w];
    logic [7:0]                    lfsr_q;
    dcache_pkg::mem_rsp_t          rsp_q;

    assign mem_rsp_o = rsp_q;

    // Galois form of x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    // Two bits give a wait of 0 to 3 cycles
    task automatic draw_delay(output int d);
        d = 0;
        for (int i = 0; i < 2; i++) begin
            d = (d << 1) | lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    initial begin
        int                            wait_left;
        logic                          pending;
        logic                          fire;
        logic [dcache_pkg::data_w-1:0] rdata;

        lfsr_q    = SEED;
        rsp_q     = '0;
        pending   = 1'b0;
        wait_left = 0;
        rdata     = '0;
        for (int a = 0; a < 2 ** dcache_pkg::addr_w; a++) begin
            mem[a] = a ^ FILL_XOR;
        end
        forever begin
            @(posedge clk_i);
            fire = 1'b0;
            if (rst_i) begin
                pending = 1'b0;
            end else if (!rsp_q.ready && mem_req_i.valid) begin
                // Ready high on this edge already ended the previous transfer
                if (!pending) begin
                    pending = 1'b1;
                    draw_delay(wait_left);
                end
                if (wait_left == 0) begin
                    pending = 1'b0;
                    fire    = 1'b1;
                    for (int b = 0; b < dcache_pkg::strb_w; b++) begin
                        if (mem_req_i.wstrb[b]) begin
                            mem[mem_req_i.addr][8*b +: 8] = mem_req_i.wdata[8*b +: 8];
                        end
                    end
                    rdata = mem[mem_req_i.addr];
                end else begin
                    wait_left--;
                end
            end
            #1;
            rsp_q.ready = fire;
            rsp_q.rdata = rdata;
        end
    end

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int INDEX_W = 9,
    parameter int TAG_W   = 8
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  dcache_pkg::cpu_req_t            cpu_req_i,
    output logic                            stall_o,
    output logic [dcache_pkg::data_w-1:0]   rdata_o,
    output dcache_pkg::mem_req_t            mem_req_o,
    input  dcache_pkg::mem_rsp_t            mem_rsp_i
);

    logic [INDEX_W-1:0]            req_index;
    logic [TAG_W-1:0]              req_tag;
    dcache_pkg::cache_state_e      state;
    dcache_pkg::fill_src_e         fill_src;
    logic                          ram_re;
    logic                          ram_we;
    logic                          meta_we;
    logic                          meta_dirty;
    logic                          victim_load;
    logic                          refill_load;
    logic                          sweep_busy;
    logic                          sweep_clear;
    logic [INDEX_W-1:0]            sweep_index;
    logic                          hit;
    logic                          valid;
    logic                          dirty;
    logic [TAG_W-1:0]              victim_tag;
    logic [dcache_pkg::data_w-1:0] ram_rdata;
    logic [dcache_pkg::data_w-1:0] ram_wdata;
    logic [dcache_pkg::strb_w-1:0] ram_wmask;

    assign req_index = cpu_req_i.addr[INDEX_W-1:0];
    assign req_tag   = cpu_req_i.addr[INDEX_W +: TAG_W];

    dcache_ctrl u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i), .cpu_req_i(cpu_req_i), .sweep_busy_i(sweep_busy),
        .hit_i(hit), .valid_i(valid), .dirty_i(dirty), .mem_ready_i(mem_rsp_i.ready),
        .state_o(state), .ram_re_o(ram_re), .ram_we_o(ram_we), .fill_src_o(fill_src),
        .meta_we_o(meta_we), .meta_dirty_o(meta_dirty), .victim_load_o(victim_load),
        .refill_load_o(refill_load), .stall_o(stall_o)
    );

    dcache_init_sweep #(.INDEX_W(INDEX_W)) u_sweep (
        .clk_i(clk_i), .rst_i(rst_i), .clear_o(sweep_clear),
        .clear_index_o(sweep_index), .busy_o(sweep_busy)
    );

    dcache_meta #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) u_meta (
        .clk_i(clk_i), .rst_i(rst_i), .lookup_index_i(req_index), .lookup_tag_i(req_tag),
        .update_i(meta_we), .update_dirty_i(meta_dirty), .update_tag_i(req_tag),
        .clear_i(sweep_clear), .clear_index_i(sweep_index), .hit_o(hit),
        .valid_o(valid), .dirty_o(dirty), .victim_tag_o(victim_tag)
    );

    dcache_data_ram #(.INDEX_W(INDEX_W)) u_data_ram (
        .clk_i(clk_i), .we_i(ram_we), .wmask_i(ram_wmask), .windex_i(req_index),
        .wdata_i(ram_wdata), .re_i(ram_re), .rindex_i(req_index), .rdata_o(ram_rdata)
    );

    dcache_datapath #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) u_datapath (
        .clk_i(clk_i), .rst_i(rst_i), .cpu_req_i(cpu_req_i), .state_i(state),
        .ram_rdata_i(ram_rdata), .victim_tag_i(victim_tag), .mem_rsp_i(mem_rsp_i),
        .victim_load_i(victim_load), .refill_load_i(refill_load), .fill_src_i(fill_src),
        .ram_wdata_o(ram_wdata), .ram_wmask_o(ram_wmask), .mem_req_o(mem_req_o),
        .rdata_o(rdata_o)
    );

endmodule

// File: rtl/dcache_datapath.sv
`timescale 1ns/1ps

module dcache_datapath #(
    parameter int INDEX_W = 9,
    parameter int TAG_W   = 8
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  dcache_pkg::cpu_req_t            cpu_req_i,
    input  dcache_pkg::cache_state_e        state_i,
    input  logic [dcache_pkg::data_w-1:0]   ram_rdata_i,
    input  logic [TAG_W-1:0]                victim_tag_i,
    input  dcache_pkg::mem_rsp_t            mem_rsp_i,
    input  logic                            victim_load_i,
    input  logic                            refill_load_i,
    input  dcache_pkg::fill_src_e           fill_src_i,
    output logic [dcache_pkg::data_w-1:0]   ram_wdata_o,
    output logic [dcache_pkg::strb_w-1:0]   ram_wmask_o,
    output dcache_pkg::mem_req_t            mem_req_o,
    output logic [dcache_pkg::data_w-1:0]   rdata_o
);

    logic [dcache_pkg::addr_w-1:0] mem_addr_q;
    logic [dcache_pkg::data_w-1:0] mem_wdata_q;
    logic [dcache_pkg::strb_w-1:0] mem_wstrb_q;
    logic [dcache_pkg::data_w-1:0] refill_q;
    logic                          read_setup;

    // Read request loaded in idle or when the write-back completes
    assign read_setup = (state_i == dcache_pkg::st_idle) ||
                        (state_i == dcache_pkg::st_mem_write && mem_rsp_i.ready);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_wstrb_q <= '0;
        end else if (victim_load_i) begin
            mem_wstrb_q <= '1;
        end else if (read_setup) begin
            mem_wstrb_q <= '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (victim_load_i) begin
            mem_addr_q  <= {victim_tag_i, cpu_req_i.addr[INDEX_W-1:0]};
            mem_wdata_q <= ram_rdata_i;
        end else if (read_setup) begin
            mem_addr_q <= cpu_req_i.addr;
        end
    end

    // Store bytes over the fetched word, a plain copy for loads
    always_ff @(posedge clk_i) begin
        if (refill_load_i) begin
            for (int b = 0; b < dcache_pkg::strb_w; b++) begin
                refill_q[8*b +: 8] <= cpu_req_i.wmask[b] ? cpu_req_i.wdata[8*b +: 8]
                                                         : mem_rsp_i.rdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_i == dcache_pkg::st_cache_read) begin
            rdata_o <= ram_rdata_i;
        end
    end

    assign ram_wdata_o = (fill_src_i == dcache_pkg::fill_buf) ? refill_q : cpu_req_i.wdata;
    assign ram_wmask_o = (fill_src_i == dcache_pkg::fill_buf) ? '1 : cpu_req_i.wmask;

    assign mem_req_o.valid = (state_i == dcache_pkg::st_mem_read) ||
                             (state_i == dcache_pkg::st_mem_write);
    assign mem_req_o.addr  = mem_addr_q;
    assign mem_req_o.wdata = mem_wdata_q;
    assign mem_req_o.wstrb = mem_wstrb_q;

endmodule

// File: rtl/dcache_data_ram.sv
`timescale 1ns/1ps

module dcache_data_ram #(
    parameter int INDEX_W = 9
) (
    input  logic                            clk_i,
    input  logic                            we_i,
    input  logic [dcache_pkg::strb_w-1:0]   wmask_i,
    input  logic [INDEX_W-1:0]              windex_i,
    input  logic [dcache_pkg::data_w-1:0]   wdata_i,
    input  logic                            re_i,
    input  logic [INDEX_W-1:0]              rindex_i,
    output logic [dcache_pkg::data_w-1:0]   rdata_o
);

    logic [dcache_pkg::data_w-1:0] mem [2 ** INDEX_W];
    logic                          same_line;

    assign same_line = we_i && (windex_i == rindex_i);

    always_ff @(posedge clk_i) begin
        for (int b = 0; b < dcache_pkg::strb_w; b++) begin
            if (we_i && wmask_i[b]) begin
                mem[windex_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
            // Write-first per byte
            if (re_i) begin
                if (same_line && wmask_i[b]) begin
                    rdata_o[8*b +: 8] <= wdata_i[8*b +: 8];
                end else begin
                    rdata_o[8*b +: 8] <= mem[rindex_i][8*b +: 8];
                end
            end
        end
    end

endmodule

// File: rtl/dcache_meta.sv
`timescale 1ns/1ps

module dcache_meta #(
    parameter int INDEX_W = 9,
    parameter int TAG_W   = 8
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic [INDEX_W-1:0] lookup_index_i,
    input  logic [TAG_W-1:0]   lookup_tag_i,
    input  logic               update_i,
    input  logic               update_dirty_i,
    input  logic [TAG_W-1:0]   update_tag_i,
    input  logic               clear_i,
    input  logic [INDEX_W-1:0] clear_index_i,
    output logic               hit_o,
    output logic               valid_o,
    output logic               dirty_o,
    output logic [TAG_W-1:0]   victim_tag_o
);

    localparam int lines = 2 ** INDEX_W;

    logic [TAG_W-1:0] tag_q [lines];
    logic [lines-1:0] valid_q;
    logic [lines-1:0] dirty_q;

    // Line state, cleared by the sweep after reset
    always_ff @(posedge clk_i) begin
        if (clear_i) begin
            valid_q[clear_index_i] <= 1'b0;
            dirty_q[clear_index_i] <= 1'b0;
        end else if (update_i) begin
            valid_q[lookup_index_i] <= 1'b1;
            dirty_q[lookup_index_i] <= update_dirty_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i) begin
            tag_q[lookup_index_i] <= update_tag_i;
        end
    end

    assign valid_o      = valid_q[lookup_index_i];
    assign dirty_o      = dirty_q[lookup_index_i];
    assign victim_tag_o = tag_q[lookup_index_i];
    assign hit_o        = valid_o && (victim_tag_o == lookup_tag_i);

    // Controller holds off while the sweep is busy
    a_no_update_in_clear: assert property (@(posedge clk_i) disable iff (rst_i)
        !(update_i && clear_i));

endmodule

// File: rtl/dcache_init_sweep.sv
`timescale 1ns/1ps

module dcache_init_sweep #(
    parameter int INDEX_W = 9
) (
    input  logic               clk_i,
    input  logic               rst_i,
    output logic               clear_o,
    output logic [INDEX_W-1:0] clear_index_o,
    output logic               busy_o
);

    logic [INDEX_W-1:0] index_q;
    logic               busy_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            index_q <= '0;
            busy_q  <= 1'b1;
        end else if (busy_q) begin
            index_q <= index_q + 1'b1;
            // Last line cleared
            if (&index_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign clear_o       = busy_q;
    assign clear_index_o = index_q;
    assign busy_o        = busy_q;

    a_busy_once: assert property (@(posedge clk_i) disable iff (rst_i)
        !busy_q |=> !busy_q);

endmodule

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  dcache_pkg::cpu_req_t     cpu_req_i,
    input  logic                     sweep_busy_i,
    input  logic                     hit_i,
    input  logic                     valid_i,
    input  logic                     dirty_i,
    input  logic                     mem_ready_i,
    output dcache_pkg::cache_state_e state_o,
    output logic                     ram_re_o,
    output logic                     ram_we_o,
    output dcache_pkg::fill_src_e    fill_src_o,
    output logic                     meta_we_o,
    output logic                     meta_dirty_o,
    output logic                     victim_load_o,
    output logic                     refill_load_o,
    output logic                     stall_o
);

    dcache_pkg::cache_state_e state_q;
    dcache_pkg::cache_state_e state_d;
    logic                     lookup_q;
    logic                     is_load;
    logic                     is_full;
    logic                     victim_dirty;
    logic                     req_active;

    assign is_load      = (cpu_req_i.wmask == '0);
    assign is_full      = &cpu_req_i.wmask;
    assign victim_dirty = valid_i && dirty_i && !hit_i;
    assign req_active   = cpu_req_i.sel && !sweep_busy_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::st_idle: begin
                if (req_active) begin
                    if (hit_i) begin
                        state_d = is_load ? dcache_pkg::st_cache_read
                                          : dcache_pkg::st_cache_write;
                    end else if (victim_dirty) begin
                        // Victim word is on the array output one cycle after lookup
                        if (lookup_q) begin
                            state_d = dcache_pkg::st_mem_write;
                        end
                    end else if (is_load || !is_full) begin
                        state_d = dcache_pkg::st_mem_read;
                    end else begin
                        state_d = dcache_pkg::st_cache_write;
                    end
                end
            end
            dcache_pkg::st_mem_write: begin
                if (mem_ready_i) begin
                    // Full-word store needs no fetch
                    state_d = is_full ? dcache_pkg::st_cache_write
                                      : dcache_pkg::st_mem_read;
                end
            end
            dcache_pkg::st_mem_read: begin
                if (mem_ready_i) begin
                    state_d = dcache_pkg::st_cache_write;
                end
            end
            dcache_pkg::st_cache_write: begin
                state_d = is_load ? dcache_pkg::st_cache_read : dcache_pkg::st_done;
            end
            dcache_pkg::st_cache_read: begin
                state_d = dcache_pkg::st_done;
            end
            dcache_pkg::st_done: begin
                state_d = dcache_pkg::st_idle;
            end
            default: begin
                state_d = dcache_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= dcache_pkg::st_idle;
            lookup_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            lookup_q <= (state_q == dcache_pkg::st_idle) && req_active;
        end
    end

    assign state_o = state_q;

    // Read in cache_write returns the word just written, used by load fills
    assign ram_re_o = (state_q == dcache_pkg::st_idle) || (state_q == dcache_pkg::st_cache_write);
    assign ram_we_o = (state_q == dcache_pkg::st_cache_write);

    // Loads and partial store misses write the refill buffer
    assign fill_src_o = (is_load || (!is_full && !hit_i)) ? dcache_pkg::fill_buf
                                                          : dcache_pkg::fill_cpu;

    assign meta_we_o    = (state_q == dcache_pkg::st_cache_write);
    assign meta_dirty_o = !is_load;

    assign victim_load_o = (state_q == dcache_pkg::st_idle) &&
                           (state_d == dcache_pkg::st_mem_write);
    assign refill_load_o = (state_q == dcache_pkg::st_mem_read) && mem_ready_i;

    assign stall_o = cpu_req_i.sel && (state_q != dcache_pkg::st_done);

    a_done_to_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        state_q == dcache_pkg::st_done |=> state_q == dcache_pkg::st_idle);

    // Write-back only for a line that was valid and dirty at lookup
    a_evict_dirty: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == dcache_pkg::st_idle ##1 state_q == dcache_pkg::st_mem_write)
        |-> $past(valid_i && dirty_i));

endmodule

// File: rtl/dcache_pkg.sv
package dcache_pkg;

    localparam int addr_w = 17;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    typedef enum logic [2:0] {
        st_idle,
        st_cache_read,
        st_cache_write,
        st_mem_read,
        st_mem_write,
        st_done
    } cache_state_e;

    // Source of array write data
    typedef enum logic {
        fill_cpu,
        fill_buf
    } fill_src_e;

    // Empty mask marks a load
    typedef struct packed {
        logic              sel;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wmask;
    } cpu_req_t;

    // Empty strobe marks a read
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              ready;
    } mem_rsp_t;

endpackage
